/* source/id_pkg.sv */
package id_pkg;

    localparam int WORD_W      = 32;
    localparam int INST_W      = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int REG_COUNT   = 32;
    localparam int CREDITS_MAX = 4;   // sets the credit counter width

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [7:0] {
        ALUOP_NOP   = 8'b0000_0000,
        ALUOP_AND   = 8'b0010_0100,
        ALUOP_OR    = 8'b0010_0101,
        ALUOP_XOR   = 8'b0010_0110,
        ALUOP_NOR   = 8'b0010_0111,
        ALUOP_SLL   = 8'b0111_1100,
        ALUOP_SRL   = 8'b0000_0010,
        ALUOP_SRA   = 8'b0000_0011,
        ALUOP_ADD   = 8'b0010_0000,
        ALUOP_ADDU  = 8'b0010_0001,
        ALUOP_ADDI  = 8'b0101_0101,
        ALUOP_ADDIU = 8'b0101_0110,
        ALUOP_SUB   = 8'b0010_0010,
        ALUOP_SUBU  = 8'b0010_0011,
        ALUOP_SLT   = 8'b0010_1010,
        ALUOP_SLTU  = 8'b0010_1011
    } aluop_t;

    typedef enum logic [2:0] {
        ALUSEL_NOP   = 3'b000,
        ALUSEL_LOGIC = 3'b001,
        ALUSEL_SHIFT = 3'b010,
        ALUSEL_ARITH = 3'b100
    } alusel_t;

    // primary opcodes, inst[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // function field of SPECIAL, inst[5:0]
    localparam logic [5:0] FUNCT_SLL  = 6'b000000;
    localparam logic [5:0] FUNCT_SRL  = 6'b000010;
    localparam logic [5:0] FUNCT_SRA  = 6'b000011;
    localparam logic [5:0] FUNCT_SLLV = 6'b000100;
    localparam logic [5:0] FUNCT_SRLV = 6'b000110;
    localparam logic [5:0] FUNCT_SRAV = 6'b000111;
    localparam logic [5:0] FUNCT_ADD  = 6'b100000;
    localparam logic [5:0] FUNCT_ADDU = 6'b100001;
    localparam logic [5:0] FUNCT_SUB  = 6'b100010;
    localparam logic [5:0] FUNCT_SUBU = 6'b100011;
    localparam logic [5:0] FUNCT_AND  = 6'b100100;
    localparam logic [5:0] FUNCT_OR   = 6'b100101;
    localparam logic [5:0] FUNCT_XOR  = 6'b100110;
    localparam logic [5:0] FUNCT_NOR  = 6'b100111;
    localparam logic [5:0] FUNCT_SLT  = 6'b101010;
    localparam logic [5:0] FUNCT_SLTU = 6'b101011;

endpackage

/* source/id_decoder.sv */
module id_decoder (
    input  id_pkg::inst_t     inst_i,
    output id_pkg::aluop_t    aluop_o,
    output id_pkg::alusel_t   alusel_o,
    output logic              reg1_read_o,
    output logic              reg2_read_o,
    output id_pkg::reg_addr_t reg1_addr_o,
    output id_pkg::reg_addr_t reg2_addr_o,
    output id_pkg::word_t     imm_o,
    output id_pkg::reg_addr_t wd_o,
    output logic              wreg_o,
    output logic              illegal_o
);
    import id_pkg::*;

    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
    logic       shift_imm;
    aluop_t     r_op;
    aluop_t     i_op;

    // result class follows from the operation
    function automatic alusel_t sel_of(aluop_t alu_op);
        case (alu_op)
            ALUOP_AND, ALUOP_OR, ALUOP_XOR, ALUOP_NOR: sel_of = ALUSEL_LOGIC;
            ALUOP_SLL, ALUOP_SRL, ALUOP_SRA:           sel_of = ALUSEL_SHIFT;
            ALUOP_NOP:                                 sel_of = ALUSEL_NOP;
            default:                                   sel_of = ALUSEL_ARITH;
        endcase
    endfunction

    assign op    = inst_i[31:26];
    assign rs    = inst_i[25:21];
    assign rt    = inst_i[20:16];
    assign rd    = inst_i[15:11];
    assign shamt = inst_i[10:6];
    assign funct = inst_i[5:0];

    assign shift_imm = (funct == FUNCT_SLL) || (funct == FUNCT_SRL) || (funct == FUNCT_SRA);

    assign reg1_addr_o = rs;
    assign reg2_addr_o = rt;

    always_comb begin
        case (funct)
            FUNCT_AND:  r_op = ALUOP_AND;
            FUNCT_OR:   r_op = ALUOP_OR;
            FUNCT_XOR:  r_op = ALUOP_XOR;
            FUNCT_NOR:  r_op = ALUOP_NOR;
            FUNCT_SLL:  r_op = ALUOP_SLL;
            FUNCT_SRL:  r_op = ALUOP_SRL;
            FUNCT_SRA:  r_op = ALUOP_SRA;
            FUNCT_SLLV: r_op = ALUOP_SLL;
            FUNCT_SRLV: r_op = ALUOP_SRL;
            FUNCT_SRAV: r_op = ALUOP_SRA;
            FUNCT_ADD:  r_op = ALUOP_ADD;
            FUNCT_ADDU: r_op = ALUOP_ADDU;
            FUNCT_SUB:  r_op = ALUOP_SUB;
            FUNCT_SUBU: r_op = ALUOP_SUBU;
            FUNCT_SLT:  r_op = ALUOP_SLT;
            FUNCT_SLTU: r_op = ALUOP_SLTU;
            default:    r_op = ALUOP_NOP;
        endcase
    end

    always_comb begin
        case (op)
            OP_ANDI:  i_op = ALUOP_AND;
            OP_ORI:   i_op = ALUOP_OR;
            OP_XORI:  i_op = ALUOP_XOR;
            OP_LUI:   i_op = ALUOP_OR;   // imm already shifted up
            OP_ADDI:  i_op = ALUOP_ADDI;
            OP_ADDIU: i_op = ALUOP_ADDIU;
            OP_SLTI:  i_op = ALUOP_SLT;
            OP_SLTIU: i_op = ALUOP_SLTU;
            default:  i_op = ALUOP_NOP;
        endcase
    end

    always_comb begin
        aluop_o     = ALUOP_NOP;
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        imm_o       = '0;
        wd_o        = rd;
        wreg_o      = 1'b0;

        case (op)
            OP_SPECIAL: begin
                if (shift_imm) begin
                    if (rs == 5'd0) begin
                        aluop_o     = r_op;
                        reg2_read_o = 1'b1;
                        imm_o       = {27'd0, shamt};   // shift amount as operand 1
                        wreg_o      = 1'b1;
                    end
                end else if ((shamt == 5'd0) && (r_op != ALUOP_NOP)) begin
                    aluop_o     = r_op;
                    reg1_read_o = 1'b1;
                    reg2_read_o = 1'b1;
                    wreg_o      = 1'b1;
                end
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                aluop_o     = i_op;
                reg1_read_o = 1'b1;
                imm_o       = {16'h0, inst_i[15:0]};
                wd_o        = rt;
                wreg_o      = 1'b1;
            end
            OP_LUI: begin
                aluop_o     = i_op;
                reg1_read_o = 1'b1;   // rs is r0 in a well-formed lui
                imm_o       = {inst_i[15:0], 16'h0};
                wd_o        = rt;
                wreg_o      = 1'b1;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                aluop_o     = i_op;
                reg1_read_o = 1'b1;
                imm_o       = {{16{inst_i[15]}}, inst_i[15:0]};
                wd_o        = rt;
                wreg_o      = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign alusel_o  = sel_of(aluop_o);
    assign illegal_o = (aluop_o == ALUOP_NOP);   // every known code has a real op

endmodule

/* source/id_regfile.sv */
module id_regfile (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              we_i,
    input  id_pkg::reg_addr_t waddr_i,
    input  id_pkg::word_t     wdata_i,
    input  logic              re1_i,
    input  id_pkg::reg_addr_t raddr1_i,
    input  logic              re2_i,
    input  id_pkg::reg_addr_t raddr2_i,
    output id_pkg::word_t     rdata1_o,
    output id_pkg::word_t     rdata2_o
);
    import id_pkg::*;

    word_t regs [REG_COUNT];
    logic  wr_en;

    assign wr_en = we_i && (waddr_i != '0);   // r0 is hardwired

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // read ports with write-through
    always_comb begin
        if (!re1_i || (raddr1_i == '0)) rdata1_o = '0;
        else if (wr_en && (waddr_i == raddr1_i)) rdata1_o = wdata_i;
        else rdata1_o = regs[raddr1_i];
    end

    always_comb begin
        if (!re2_i || (raddr2_i == '0)) rdata2_o = '0;
        else if (wr_en && (waddr_i == raddr2_i)) rdata2_o = wdata_i;
        else rdata2_o = regs[raddr2_i];
    end

    a_r0_zero: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (we_i && (waddr_i == '0)) |=> (regs[0] == '0)
    );

endmodule

/* source/id_operand_mux.sv */
module id_operand_mux (
    input  logic              read_i,
    input  id_pkg::reg_addr_t addr_i,
    input  id_pkg::word_t     rf_data_i,
    input  id_pkg::word_t     imm_i,
    input  logic              ex_wreg_i,
    input  id_pkg::reg_addr_t ex_wd_i,
    input  id_pkg::word_t     ex_wdata_i,
    input  logic              mem_wreg_i,
    input  id_pkg::reg_addr_t mem_wd_i,
    input  id_pkg::word_t     mem_wdata_i,
    output id_pkg::word_t     opnd_o
);

    logic fwd_ok;
    logic ex_hit;
    logic mem_hit;

    assign fwd_ok  = read_i && (addr_i != '0);   // r0 never forwarded
    assign ex_hit  = fwd_ok && ex_wreg_i && (ex_wd_i == addr_i);
    assign mem_hit = fwd_ok && mem_wreg_i && (mem_wd_i == addr_i);

    // youngest result wins
    always_comb begin
        if (!read_i) begin
            opnd_o = imm_i;
        end else if (ex_hit) begin
            opnd_o = ex_wdata_i;
        end else if (mem_hit) begin
            opnd_o = mem_wdata_i;
        end else begin
            opnd_o = rf_data_i;
        end
    end

endmodule

/* source/id_issue_credit.sv */
module id_issue_credit #(
    parameter int CREDITS = 2
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              inst_valid_i,
    input  logic              credit_return_i,
    input  id_pkg::aluop_t    aluop_i,
    input  id_pkg::alusel_t   alusel_i,
    input  id_pkg::word_t     opnd1_i,
    input  id_pkg::word_t     opnd2_i,
    input  id_pkg::reg_addr_t wd_i,
    input  logic              wreg_i,
    input  logic              illegal_i,
    output logic              inst_ready_o,
    output logic              issue_valid_o,
    output id_pkg::aluop_t    aluop_o,
    output id_pkg::alusel_t   alusel_o,
    output id_pkg::word_t     opnd1_o,
    output id_pkg::word_t     opnd2_o,
    output id_pkg::reg_addr_t wd_o,
    output logic              wreg_o,
    output logic              illegal_o
);
    import id_pkg::*;

    localparam int CNT_W = $clog2(CREDITS_MAX + 1);

    logic [CNT_W-1:0] credit_cnt;
    logic             accept;

    assign inst_ready_o = (credit_cnt != '0);
    assign accept       = inst_valid_i && inst_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            credit_cnt <= CNT_W'(CREDITS);
        end else begin
            case ({accept, credit_return_i})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;   // none, or take and give back
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            issue_valid_o <= 1'b0;
            wreg_o        <= 1'b0;
            illegal_o     <= 1'b0;
        end else begin
            issue_valid_o <= accept;
            illegal_o     <= accept && illegal_i;   // flagged on the issue cycle only
            if (accept) begin
                wreg_o <= wreg_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            aluop_o  <= aluop_i;
            alusel_o <= alusel_i;
            opnd1_o  <= opnd1_i;
            opnd2_o  <= opnd2_i;
            wd_o     <= wd_i;
        end
    end

    a_cnt_bound: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        credit_cnt <= CNT_W'(CREDITS)
    );

    // a full counter means nothing is in flight downstream
    a_no_spurious_return: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        credit_return_i |-> (credit_cnt != CNT_W'(CREDITS))
    );

endmodule

/* source/id_stage_top.sv */
module id_stage_top #(
    parameter int CREDITS = 2
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              inst_valid_i,
    input  id_pkg::inst_t     inst_i,
    input  logic              wb_we_i,
    input  id_pkg::reg_addr_t wb_addr_i,
    input  id_pkg::word_t     wb_data_i,
    input  logic              ex_wreg_i,
    input  id_pkg::reg_addr_t ex_wd_i,
    input  id_pkg::word_t     ex_wdata_i,
    input  logic              mem_wreg_i,
    input  id_pkg::reg_addr_t mem_wd_i,
    input  id_pkg::word_t     mem_wdata_i,
    input  logic              credit_return_i,
    output logic              inst_ready_o,
    output logic              issue_valid_o,
    output id_pkg::aluop_t    aluop_o,
    output id_pkg::alusel_t   alusel_o,
    output id_pkg::word_t     opnd1_o,
    output id_pkg::word_t     opnd2_o,
    output id_pkg::reg_addr_t wd_o,
    output logic              wreg_o,
    output logic              illegal_o
);
    import id_pkg::*;

    aluop_t    dec_aluop;
    alusel_t   dec_alusel;
    logic      reg1_read;
    logic      reg2_read;
    reg_addr_t reg1_addr;
    reg_addr_t reg2_addr;
    word_t     dec_imm;
    reg_addr_t dec_wd;
    logic      dec_wreg;
    logic      dec_illegal;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     opnd1;
    word_t     opnd2;

    id_decoder u_decoder (
        .inst_i      (inst_i),
        .aluop_o     (dec_aluop),
        .alusel_o    (dec_alusel),
        .reg1_read_o (reg1_read),
        .reg2_read_o (reg2_read),
        .reg1_addr_o (reg1_addr),
        .reg2_addr_o (reg2_addr),
        .imm_o       (dec_imm),
        .wd_o        (dec_wd),
        .wreg_o      (dec_wreg),
        .illegal_o   (dec_illegal)
    );

    id_regfile u_regfile (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .we_i     (wb_we_i),
        .waddr_i  (wb_addr_i),
        .wdata_i  (wb_data_i),
        .re1_i    (reg1_read),
        .raddr1_i (reg1_addr),
        .re2_i    (reg2_read),
        .raddr2_i (reg2_addr),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    id_operand_mux u_opnd1_mux (
        .read_i      (reg1_read),
        .addr_i      (reg1_addr),
        .rf_data_i   (rf_rdata1),
        .imm_i       (dec_imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .opnd_o      (opnd1)
    );

    id_operand_mux u_opnd2_mux (
        .read_i      (reg2_read),
        .addr_i      (reg2_addr),
        .rf_data_i   (rf_rdata2),
        .imm_i       (dec_imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .opnd_o      (opnd2)
    );

    id_issue_credit #(
        .CREDITS (CREDITS)
    ) u_issue (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .inst_valid_i    (inst_valid_i),
        .credit_return_i (credit_return_i),
        .aluop_i         (dec_aluop),
        .alusel_i        (dec_alusel),
        .opnd1_i         (opnd1),
        .opnd2_i         (opnd2),
        .wd_i            (dec_wd),
        .wreg_i          (dec_wreg),
        .illegal_i       (dec_illegal),
        .inst_ready_o    (inst_ready_o),
        .issue_valid_o   (issue_valid_o),
        .aluop_o         (aluop_o),
        .alusel_o        (alusel_o),
        .opnd1_o         (opnd1_o),
        .opnd2_o         (opnd2_o),
        .wd_o            (wd_o),
        .wreg_o          (wreg_o),
        .illegal_o       (illegal_o)
    );

endmodule

/* verification/id_stage_tb_tasks.svh */
// step to the drive point just after the rising edge
task automatic tick();
    @(posedge clk);
    #DRIVE_DELAY;
endtask

task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
        error_count++;
        $display("ERROR at %0d ns: %s expected %h, got %h", $time, name, exp, act);
    end
endtask

task automatic check_aluop(input string name, input aluop_t exp, input aluop_t act);
    if (act !== exp) begin
        error_count++;
        $display("ERROR at %0d ns: %s expected %s (%h), got %s (%h)",
                 $time, name, exp.name(), exp, act.name(), act);
    end
endtask

task automatic check_alusel(input string name, input alusel_t exp, input alusel_t act);
    if (act !== exp) begin
        error_count++;
        $display("ERROR at %0d ns: %s expected %s (%h), got %s (%h)",
                 $time, name, exp.name(), exp, act.name(), act);
    end
endtask

task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
    if (act !== exp) begin
        error_count++;
        $display("ERROR at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        error_count++;
        $display("ERROR at %0d ns: %s expected %b, got %b", $time, name, exp, act);
    end
endtask

task automatic write_reg(input reg_addr_t addr, input word_t data);
    wb_we_i   = 1'b1;
    wb_addr_i = addr;
    wb_data_i = data;
    tick();
    wb_we_i   = 1'b0;
    if (addr != '0) begin
        model_regs[addr] = data;   // r0 stays zero
    end
endtask

// present an instruction and hold it until accepted
task automatic send_inst(input inst_t inst);
    int waited;
    waited       = 0;
    inst_valid_i = 1'b1;
    inst_i       = inst;
    while (!inst_ready_o && (waited < READY_WAIT)) begin
        tick();
        waited++;
    end
    if (!inst_ready_o) begin
        error_count++;
        $display("inst_ready_o stayed low for %0d cycles, instruction never accepted", waited);
    end
    tick();
    inst_valid_i = 1'b0;
endtask

task automatic check_issue(input aluop_t op, input alusel_t sel, input word_t op1,
                           input word_t op2, input reg_addr_t wd);
    check_bit("issue_valid_o", 1'b1, issue_valid_o);
    check_aluop("aluop_o", op, aluop_o);
    check_alusel("alusel_o", sel, alusel_o);
    check_word("opnd1_o", op1, opnd1_o);
    check_word("opnd2_o", op2, opnd2_o);
    check_addr("wd_o", wd, wd_o);
    check_bit("wreg_o", 1'b1, wreg_o);
    check_bit("illegal_o", 1'b0, illegal_o);
endtask

task automatic return_credit();
    credit_return_i = 1'b1;
    tick();
    credit_return_i = 1'b0;
    check_bit("issue_valid_o", 1'b0, issue_valid_o);   // one cycle per issue
endtask

task automatic run_inst(input inst_t inst, input aluop_t op, input alusel_t sel,
                        input word_t op1, input word_t op2, input reg_addr_t wd);
    send_inst(inst);
    check_issue(op, sel, op1, op2, wd);
    return_credit();
endtask

task automatic test_reset_state();
    check_bit("issue_valid_o", 1'b0, issue_valid_o);
    check_bit("illegal_o", 1'b0, illegal_o);
    check_bit("inst_ready_o", 1'b1, inst_ready_o);
endtask

task automatic load_registers();
    for (int r = 1; r < REG_COUNT; r++) begin
        write_reg(reg_addr_t'(r), rand_bits(32));
    end
    write_reg(5'd0, 32'hDEAD_BEEF);   // dropped by the register file
endtask

task automatic test_rtype();
    logic [5:0] fn [10];
    aluop_t     ops [10];
    reg_addr_t  rs, rt, rd;
    fn  = '{FUNCT_AND, FUNCT_OR, FUNCT_XOR, FUNCT_NOR, FUNCT_ADD,
            FUNCT_ADDU, FUNCT_SUB, FUNCT_SUBU, FUNCT_SLT, FUNCT_SLTU};
    ops = '{ALUOP_AND, ALUOP_OR, ALUOP_XOR, ALUOP_NOR, ALUOP_ADD,
            ALUOP_ADDU, ALUOP_SUB, ALUOP_SUBU, ALUOP_SLT, ALUOP_SLTU};
    for (int i = 0; i < 10; i++) begin
        rs = reg_addr_t'(rand_bits(5));
        rt = reg_addr_t'(rand_bits(5));
        rd = reg_addr_t'(rand_bits(5));
        run_inst(enc_r(rs, rt, rd, 5'd0, fn[i]), ops[i],
                 (i < 4) ? ALUSEL_LOGIC : ALUSEL_ARITH, model_regs[rs], model_regs[rt], rd);
    end
    // r0 as a source reads zero
    run_inst(enc_r(5'd0, 5'd9, 5'd3, 5'd0, FUNCT_OR), ALUOP_OR, ALUSEL_LOGIC,
             '0, model_regs[9], 5'd3);
endtask

task automatic test_immediate();
    reg_addr_t   rs, rt;
    logic [15:0] neg;
    logic [15:0] pos;
    rs  = reg_addr_t'(rand_bits(5));
    rt  = reg_addr_t'(rand_bits(5));
    neg = 16'(rand_bits(16)) | 16'h8000;
    pos = 16'(rand_bits(16)) & 16'h7FFF;
    run_inst(enc_i(OP_ANDI, rs, rt, neg), ALUOP_AND, ALUSEL_LOGIC,
             model_regs[rs], {16'h0000, neg}, rt);
    run_inst(enc_i(OP_ORI, rs, rt, neg), ALUOP_OR, ALUSEL_LOGIC,
             model_regs[rs], {16'h0000, neg}, rt);
    run_inst(enc_i(OP_XORI, rs, rt, neg), ALUOP_XOR, ALUSEL_LOGIC,
             model_regs[rs], {16'h0000, neg}, rt);
    run_inst(enc_i(OP_LUI, 5'd0, rt, neg), ALUOP_OR, ALUSEL_LOGIC,
             '0, {neg, 16'h0000}, rt);
    run_inst(enc_i(OP_ADDI, rs, rt, neg), ALUOP_ADDI, ALUSEL_ARITH,
             model_regs[rs], {16'hFFFF, neg}, rt);
    run_inst(enc_i(OP_ADDIU, rs, rt, pos), ALUOP_ADDIU, ALUSEL_ARITH,
             model_regs[rs], {16'h0000, pos}, rt);
    run_inst(enc_i(OP_ADDIU, rs, rt, neg), ALUOP_ADDIU, ALUSEL_ARITH,
             model_regs[rs], {16'hFFFF, neg}, rt);
    run_inst(enc_i(OP_SLTI, rs, rt, neg), ALUOP_SLT, ALUSEL_ARITH,
             model_regs[rs], {16'hFFFF, neg}, rt);
    run_inst(enc_i(OP_SLTIU, rs, rt, neg), ALUOP_SLTU, ALUSEL_ARITH,
             model_regs[rs], {16'hFFFF, neg}, rt);
endtask

task automatic test_shifts();
    reg_addr_t  rs, rt, rd;
    logic [4:0] sa;
    rs = reg_addr_t'(rand_bits(5));
    rt = reg_addr_t'(rand_bits(5));
    rd = reg_addr_t'(rand_bits(5));
    sa = 5'(rand_bits(5));
    run_inst(enc_r(5'd0, rt, rd, sa, FUNCT_SLL), ALUOP_SLL, ALUSEL_SHIFT,
             {27'd0, sa}, model_regs[rt], rd);
    run_inst(enc_r(5'd0, rt, rd, sa, FUNCT_SRL), ALUOP_SRL, ALUSEL_SHIFT,
             {27'd0, sa}, model_regs[rt], rd);
    run_inst(enc_r(5'd0, rt, rd, sa, FUNCT_SRA), ALUOP_SRA, ALUSEL_SHIFT,
             {27'd0, sa}, model_regs[rt], rd);
    run_inst(enc_r(rs, rt, rd, 5'd0, FUNCT_SLLV), ALUOP_SLL, ALUSEL_SHIFT,
             model_regs[rs], model_regs[rt], rd);
    run_inst(enc_r(rs, rt, rd, 5'd0, FUNCT_SRLV), ALUOP_SRL, ALUSEL_SHIFT,
             model_regs[rs], model_regs[rt], rd);
    run_inst(enc_r(rs, rt, rd, 5'd0, FUNCT_SRAV), ALUOP_SRA, ALUSEL_SHIFT,
             model_regs[rs], model_regs[rt], rd);
endtask

task automatic test_forwarding();
    word_t fx, fm, fw;
    fx          = rand_bits(32);
    fm          = rand_bits(32);
    fw          = rand_bits(32);
    ex_wreg_i   = 1'b1;
    ex_wd_i     = 5'd5;
    ex_wdata_i  = fx;
    mem_wreg_i  = 1'b1;
    mem_wd_i    = 5'd5;
    mem_wdata_i = fm;
    run_inst(enc_r(5'd5, 5'd6, 5'd7, 5'd0, FUNCT_ADD), ALUOP_ADD, ALUSEL_ARITH,
             fx, model_regs[6], 5'd7);
    ex_wd_i  = 5'd8;   // only memory matches rt
    mem_wd_i = 5'd6;
    run_inst(enc_r(5'd5, 5'd6, 5'd7, 5'd0, FUNCT_SUB), ALUOP_SUB, ALUSEL_ARITH,
             model_regs[5], fm, 5'd7);
    ex_wreg_i  = 1'b0;
    mem_wreg_i = 1'b0;
    wb_we_i    = 1'b1;   // write-back in the accepting cycle
    wb_addr_i  = 5'd6;
    wb_data_i  = fw;
    send_inst(enc_r(5'd5, 5'd6, 5'd7, 5'd0, FUNCT_ADDU));
    wb_we_i       = 1'b0;
    model_regs[6] = fw;
    check_issue(ALUOP_ADDU, ALUSEL_ARITH, model_regs[5], fw, 5'd7);
    return_credit();
endtask

task automatic test_credits();
    send_inst(enc_r(5'd1, 5'd2, 5'd3, 5'd0, FUNCT_OR));
    check_issue(ALUOP_OR, ALUSEL_LOGIC, model_regs[1], model_regs[2], 5'd3);
    send_inst(enc_r(5'd4, 5'd5, 5'd6, 5'd0, FUNCT_XOR));
    check_issue(ALUOP_XOR, ALUSEL_LOGIC, model_regs[4], model_regs[5], 5'd6);
    check_bit("inst_ready_o", 1'b0, inst_ready_o);
    inst_valid_i = 1'b1;
    inst_i       = enc_r(5'd7, 5'd8, 5'd9, 5'd0, FUNCT_NOR);
    repeat (3) begin
        tick();
        check_bit("inst_ready_o", 1'b0, inst_ready_o);
        check_bit("issue_valid_o", 1'b0, issue_valid_o);
    end
    return_credit();
    check_bit("inst_ready_o", 1'b1, inst_ready_o);
    send_inst(enc_r(5'd7, 5'd8, 5'd9, 5'd0, FUNCT_NOR));
    check_issue(ALUOP_NOR, ALUSEL_LOGIC, model_regs[7], model_regs[8], 5'd9);
    return_credit();
    return_credit();
endtask

task automatic test_illegal();
    inst_t bad [2];
    bad[0] = enc_i(6'b111111, 5'd3, 5'd4, 16'(rand_bits(16)));
    bad[1] = enc_r(5'd3, 5'd4, 5'd5, 5'd0, 6'b001000);   // unknown function code
    for (int i = 0; i < 2; i++) begin
        send_inst(bad[i]);
        check_bit("issue_valid_o", 1'b1, issue_valid_o);
        check_bit("illegal_o", 1'b1, illegal_o);
        check_aluop("aluop_o", ALUOP_NOP, aluop_o);
        check_alusel("alusel_o", ALUSEL_NOP, alusel_o);
        check_bit("wreg_o", 1'b0, wreg_o);
        return_credit();
        check_bit("illegal_o", 1'b0, illegal_o);
    end
endtask

/* verification/id_stage_tb.sv */
module id_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import id_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int DRIVE_DELAY   = 10;
    localparam int RESET_CYCLES  = 5;
    localparam int NUM_INSTS     = 40;   // upper bound on instructions sent
    localparam int TEST_CYCLES   = RESET_CYCLES + REG_COUNT + 3 * NUM_INSTS;
    localparam int MARGIN_CYCLES = 100;
    localparam int READY_WAIT    = 20;

    logic        clk;
    logic        rst_n_i;
    logic        inst_valid_i;
    inst_t       inst_i;
    logic        wb_we_i;
    reg_addr_t   wb_addr_i;
    word_t       wb_data_i;
    logic        ex_wreg_i;
    reg_addr_t   ex_wd_i;
    word_t       ex_wdata_i;
    logic        mem_wreg_i;
    reg_addr_t   mem_wd_i;
    word_t       mem_wdata_i;
    logic        credit_return_i;
    logic        inst_ready_o;
    logic        issue_valid_o;
    aluop_t      aluop_o;
    alusel_t     alusel_o;
    word_t       opnd1_o;
    word_t       opnd2_o;
    reg_addr_t   wd_o;
    logic        wreg_o;
    logic        illegal_o;

    logic [15:0] lfsr;
    word_t       model_regs [REG_COUNT];   // expected register contents
    int          error_count;

    id_stage_top #(
        .CREDITS (2)
    ) uut (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .inst_valid_i    (inst_valid_i),
        .inst_i          (inst_i),
        .wb_we_i         (wb_we_i),
        .wb_addr_i       (wb_addr_i),
        .wb_data_i       (wb_data_i),
        .ex_wreg_i       (ex_wreg_i),
        .ex_wd_i         (ex_wd_i),
        .ex_wdata_i      (ex_wdata_i),
        .mem_wreg_i      (mem_wreg_i),
        .mem_wd_i        (mem_wd_i),
        .mem_wdata_i     (mem_wdata_i),
        .credit_return_i (credit_return_i),
        .inst_ready_o    (inst_ready_o),
        .issue_valid_o   (issue_valid_o),
        .aluop_o         (aluop_o),
        .alusel_o        (alusel_o),
        .opnd1_o         (opnd1_o),
        .opnd2_o         (opnd2_o),
        .wd_o            (wd_o),
        .wreg_o          (wreg_o),
        .illegal_o       (illegal_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // 16-bit galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};   // one step per bit
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic inst_t enc_r(input reg_addr_t rs, input reg_addr_t rt,
                                    input reg_addr_t rd, input logic [4:0] sa,
                                    input logic [5:0] fn);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic inst_t enc_i(input logic [5:0] op, input reg_addr_t rs,
                                    input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    `include "id_stage_tb_tasks.svh"

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("test failed");
        $finish;
    end

    initial begin
        clk             = 1'b0;
        rst_n_i         = 1'b0;
        inst_valid_i    = 1'b0;
        inst_i          = '0;
        wb_we_i         = 1'b0;
        wb_addr_i       = '0;
        wb_data_i       = '0;
        ex_wreg_i       = 1'b0;
        ex_wd_i         = '0;
        ex_wdata_i      = '0;
        mem_wreg_i      = 1'b0;
        mem_wd_i        = '0;
        mem_wdata_i     = '0;
        credit_return_i = 1'b0;
        lfsr            = 16'd43700;
        error_count     = 0;
        for (int r = 0; r < REG_COUNT; r++) begin
            model_regs[r] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n_i = 1'b1;

        test_reset_state();
        load_registers();
        test_rtype();
        test_immediate();
        test_shifts();
        test_forwarding();
        test_credits();
        test_illegal();

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+verification
source/id_pkg.sv
source/id_decoder.sv
source/id_regfile.sv
source/id_operand_mux.sv
source/id_issue_credit.sv
source/id_stage_top.sv
verification/id_stage_tb.sv
